// File: system_bus.f
hw/sysbus_pkg.sv
hw/clock_enables.sv
hw/main_decode.sv
hw/main_bus.sv
hw/work_ram.sv
hw/z80_bus.sv
hw/system_bus.sv
bench/system_bus_tb.sv

// File: bench/system_bus_tb.sv
/*
 * Testbench for the console bus fabric
 * Clock enable counts, then a table of 68K and Z80 transfers
 * ROM model with the toggle handshake and a random answer delay
 */
`timescale 1ns/1ps
`default_nettype none

module system_bus_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int ROM_BYTES = 'h400000;
	localparam int HS_LIMIT = 100;
	localparam int NUM_ROWS = 50;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + 2000;

	// Row fields
	localparam logic M68K = 1'b0;
	localparam logic Z80 = 1'b1;
	localparam logic RD = 1'b1;
	localparam logic WR = 1'b0;
	// Strobes as {uds_n, lds_n}
	localparam logic [1:0] LW = 2'b00;
	localparam logic [1:0] LU = 2'b01;
	localparam logic [1:0] LL = 2'b10;
	// What a row checks
	localparam logic [1:0] K_NONE = 2'd0;
	localparam logic [1:0] K_DATA = 2'd1;
	localparam logic [1:0] K_ROM = 2'd2;
	localparam logic [1:0] K_CTRL = 2'd3;

	localparam int P_DTACK = 0;
	localparam int P_WAIT = 1;

	typedef struct packed {
		logic        is_z80;
		logic [23:0] addr;
		logic [15:0] wdata;
		logic        rnw;
		logic [1:0]  strb_n;
		logic [1:0]  kind;
		logic [15:0] exp_val;
	} row_t;

	logic                        MCLK = 1'b0;
	logic                        reset;
	sysbus_pkg::m68k_req_t       m68k_req;
	logic [15:0]                 m68k_rdata;
	logic                        m68k_dtack_n;
	sysbus_pkg::z80_req_t        z80_req;
	logic [7:0]                  z80_rdata;
	logic                        z80_wait_n;
	logic [sysbus_pkg::MBUS_AW-1:0] rom_addr;
	logic                        rom_req;
	logic                        rom_ack;
	logic [15:0]                 rom_data;
	logic                        z80_reset_n;
	logic                        z80_busreq_n;
	logic                        m68k_ce_p;
	logic                        m68k_ce_n;
	logic                        z80_ce;

	logic [31:0]                 rng = 32'h7631;
	logic [22:0]                 cur_word;
	int                          rom_reqs = 0;
	int                          rom_delay;
	int                          value_errors = 0;
	int                          other_errors = 0;
	int                          row_idx;

	// --------------------------------------------------
	// Stimulus table
	// master, byte address, write data, rnw, strobes, check, expected
	row_t rows [NUM_ROWS] = '{
		// Work RAM lanes and the FFxxxx mirror
		{M68K, 24'hE01000, 16'h1234, WR, LW, K_NONE, 16'h0000},
		{M68K, 24'hE01000, 16'hABCD, WR, LU, K_NONE, 16'h0000},
		{M68K, 24'hFF1000, 16'h0000, RD, LW, K_DATA, 16'hAB34},
		{M68K, 24'hE01000, 16'h99EF, WR, LL, K_NONE, 16'h0000},
		{M68K, 24'hFF1000, 16'h0000, RD, LW, K_DATA, 16'hABEF},
		{M68K, 24'hE0FFFE, 16'h5AA5, WR, LW, K_NONE, 16'h0000},
		{M68K, 24'hFFFFFE, 16'h0000, RD, LW, K_DATA, 16'h5AA5},
		// ROM and unmapped space
		{M68K, 24'h000000, 16'h0000, RD, LW, K_ROM, 16'h0000},
		{M68K, 24'h012346, 16'h0000, RD, LW, K_ROM, 16'h0000},
		{M68K, 24'h3FFFFE, 16'h0000, RD, LW, K_ROM, 16'h0000},
		{M68K, 24'h400000, 16'h0000, RD, LW, K_DATA, 16'h0000},
		{M68K, 24'h900000, 16'h0000, RD, LW, K_DATA, 16'h0000},
		// Control register, expected {busreq_n, reset_n} after writes
		{M68K, 24'hA11100, 16'h0000, RD, LW, K_DATA, 16'h0100},
		{M68K, 24'hA11200, 16'h0000, RD, LW, K_DATA, 16'h0000},
		{M68K, 24'hA11100, 16'hFFFF, WR, LW, K_CTRL, 16'h0000},
		{M68K, 24'hA11200, 16'hFFFF, WR, LW, K_CTRL, 16'h0001},
		{M68K, 24'hA11100, 16'h0000, RD, LW, K_DATA, 16'h0000},
		{M68K, 24'hA11200, 16'h0000, RD, LW, K_DATA, 16'h0100},
		// Sound bus, granted
		{M68K, 24'hA00000, 16'h3C3C, WR, LU, K_NONE, 16'h0000},
		{M68K, 24'hA00001, 16'h7171, WR, LL, K_NONE, 16'h0000},
		{M68K, 24'hA01FFF, 16'h9696, WR, LL, K_NONE, 16'h0000},
		{M68K, 24'hA00000, 16'h0000, RD, LU, K_DATA, 16'h3C3C},
		{M68K, 24'hA00001, 16'h0000, RD, LL, K_DATA, 16'h7171},
		{M68K, 24'hA01FFF, 16'h0000, RD, LL, K_DATA, 16'h9696},
		{Z80,  24'h000000, 16'h0000, RD, LW, K_DATA, 16'h003C},
		{Z80,  24'h000001, 16'h0000, RD, LW, K_DATA, 16'h0071},
		{Z80,  24'h001FFF, 16'h0000, RD, LW, K_DATA, 16'h0096},
		{M68K, 24'hA04000, 16'h0000, RD, LU, K_DATA, 16'hFFFF},
		{M68K, 24'hA05FFF, 16'h0000, RD, LL, K_DATA, 16'hFFFF},
		// Grant removed
		{M68K, 24'hA11100, 16'h0000, WR, LW, K_CTRL, 16'h0003},
		{M68K, 24'hA00000, 16'h5555, WR, LU, K_NONE, 16'h0000},
		{M68K, 24'hA00000, 16'h0000, RD, LU, K_DATA, 16'hFFFF},
		{Z80,  24'h000000, 16'h0000, RD, LW, K_DATA, 16'h003C},
		// Banked window, bank 1FE points at FF0000, LSB first
		{M68K, 24'hE00000, 16'hC3A5, WR, LW, K_NONE, 16'h0000},
		{M68K, 24'hE00002, 16'h1E2F, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0000, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h006000, 16'h0001, WR, LW, K_NONE, 16'h0000},
		{Z80,  24'h008000, 16'h0000, RD, LW, K_DATA, 16'h00C3},
		{Z80,  24'h008001, 16'h0000, RD, LW, K_DATA, 16'h00A5},
		{Z80,  24'h008002, 16'h0000, RD, LW, K_DATA, 16'h001E},
		{Z80,  24'h008003, 16'h0000, RD, LW, K_DATA, 16'h002F},
		{Z80,  24'h008003, 16'h0077, WR, LW, K_NONE, 16'h0000},
		{M68K, 24'hFF0002, 16'h0000, RD, LW, K_DATA, 16'h1E77}
	};

	system_bus #(
		.ROM_BYTES (ROM_BYTES)
	) UUT (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_req     (m68k_req),
		.m68k_rdata   (m68k_rdata),
		.m68k_dtack_n (m68k_dtack_n),
		.z80_req      (z80_req),
		.z80_rdata    (z80_rdata),
		.z80_wait_n   (z80_wait_n),
		.rom_addr     (rom_addr),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.rom_data     (rom_data),
		.z80_reset_n  (z80_reset_n),
		.z80_busreq_n (z80_busreq_n),
		.m68k_ce_p    (m68k_ce_p),
		.m68k_ce_n    (m68k_ce_n),
		.z80_ce       (z80_ce)
	);

	always #(CLK_PERIOD / 2) MCLK = ~MCLK;

	// --------------------------------------------------
	// Helpers
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic probe(input int sel);
		if (sel == P_DTACK)
			return m68k_dtack_n;
		return z80_wait_n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Samples at falling edges until the level shows up
	task automatic wait_for(input int sel, input logic level, input string what,
		output logic ok);
		int n;
		n = 0;
		@(negedge MCLK);
		while (probe(sel) !== level && n < HS_LIMIT) begin
			@(negedge MCLK);
			n++;
		end
		ok = probe(sel) === level;
		assert (ok) else begin
			$display("Timeout at %0d ns while waiting for %s", $time, what);
			other_errors++;
		end
	endtask

	task automatic note_pulse(input string name, input logic pulse, input int c,
		input int period, inout int last, inout int count);
		if (pulse) begin
			if (last >= 0) begin
				check_count({name, " spacing"}, c - last, period);
			end
			last = c;
			count++;
		end
	endtask

	task automatic count_enables();
		int c;
		int last_p, last_n, last_z;
		int cnt_p, cnt_n, cnt_z;
		last_p = -1;
		last_n = -1;
		last_z = -1;
		cnt_p = 0;
		cnt_n = 0;
		cnt_z = 0;
		@(posedge MCLK);
		for (c = 1; c <= 210; c++) begin
			@(negedge MCLK);
			assert (!(m68k_ce_p && m68k_ce_n)) else begin
				$display("Both 68K phase enables high at %0d ns", $time);
				other_errors++;
			end
			note_pulse("m68k_ce_p", m68k_ce_p, c, 7, last_p, cnt_p);
			note_pulse("m68k_ce_n", m68k_ce_n, c, 7, last_n, cnt_n);
			note_pulse("z80_ce", z80_ce, c, 15, last_z, cnt_z);
		end
		check_count("m68k_ce_p pulses", cnt_p, 30);
		check_count("m68k_ce_n pulses", cnt_n, 30);
		check_count("z80_ce pulses", cnt_z, 14);
	endtask

	// --------------------------------------------------
	// Master ports
	task automatic m68k_cycle(input row_t r, output logic [15:0] got, output logic ok);
		logic done;
		@(posedge MCLK);
		#DRIVE_DELAY;
		m68k_req.addr = r.addr[23:1];
		m68k_req.wdata = r.wdata;
		m68k_req.rnw = r.rnw;
		m68k_req.uds_n = r.strb_n[1];
		m68k_req.lds_n = r.strb_n[0];
		m68k_req.as_n = 1'b0;
		wait_for(P_DTACK, 1'b0, "m68k_dtack_n low", ok);
		got = m68k_rdata;
		@(posedge MCLK);
		#DRIVE_DELAY;
		m68k_req.as_n = 1'b1;
		m68k_req.uds_n = 1'b1;
		m68k_req.lds_n = 1'b1;
		wait_for(P_DTACK, 1'b1, "m68k_dtack_n high", done);
	endtask

	task automatic z80_cycle(input row_t r, output logic [15:0] got, output logic ok);
		@(posedge MCLK);
		#DRIVE_DELAY;
		z80_req.addr = r.addr[15:0];
		z80_req.wdata = r.wdata[7:0];
		z80_req.rd_n = !r.rnw;
		z80_req.wr_n = r.rnw;
		z80_req.mreq_n = 1'b0;
		wait_for(P_WAIT, 1'b1, "z80_wait_n high", ok);
		got = {8'h00, z80_rdata};
		@(posedge MCLK);
		#DRIVE_DELAY;
		z80_req.mreq_n = 1'b1;
		z80_req.rd_n = 1'b1;
		z80_req.wr_n = 1'b1;
	endtask

	task automatic run_row(input row_t r);
		logic [15:0] got;
		logic        ok;
		int          roms_before;
		string       name;
		roms_before = rom_reqs;
		if (r.is_z80) begin
			name = "z80_rdata";
			z80_cycle(r, got, ok);
		end else begin
			name = "m68k_rdata";
			cur_word = r.addr[23:1];
			m68k_cycle(r, got, ok);
		end
		if (ok) begin
			case (r.kind)
				K_DATA: check_value(name, got, r.exp_val);
				// ROM word is its word address XOR 5A5A
				K_ROM: check_value(name, got, r.addr[16:1] ^ 16'h5A5A);
				K_CTRL: begin
					check_value("z80_busreq_n", z80_busreq_n, r.exp_val[1]);
					check_value("z80_reset_n", z80_reset_n, r.exp_val[0]);
				end
				default: ;
			endcase
		end
		check_count("ROM requests", rom_reqs - roms_before, r.kind == K_ROM);
	endtask

	task automatic finish_run();
		$display("Errors: %0d wrong values, %0d protocol failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	// --------------------------------------------------
	// ROM model answering the toggle request
	always begin
		@(negedge MCLK);
		if (!reset && rom_req !== rom_ack) begin
			rom_reqs++;
			check_value("rom_addr", rom_addr, cur_word);
			rng = xorshift(rng);
			rom_delay = rng % 5;
			repeat (rom_delay) @(posedge MCLK);
			@(posedge MCLK);
			#DRIVE_DELAY;
			rom_data = rom_addr[15:0] ^ 16'h5A5A;
			rom_ack = rom_req;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
		other_errors++;
		finish_run();
	end

	initial begin
		reset = 1'b1;
		m68k_req.addr = '0;
		m68k_req.wdata = '0;
		m68k_req.rnw = 1'b1;
		m68k_req.as_n = 1'b1;
		m68k_req.uds_n = 1'b1;
		m68k_req.lds_n = 1'b1;
		z80_req.addr = '0;
		z80_req.wdata = '0;
		z80_req.mreq_n = 1'b1;
		z80_req.rd_n = 1'b1;
		z80_req.wr_n = 1'b1;
		rom_ack = 1'b0;
		rom_data = '0;
		cur_word = '0;
		repeat (2) @(posedge MCLK);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Idle levels straight after reset
		@(negedge MCLK);
		check_value("m68k_dtack_n", m68k_dtack_n, 1'b1);
		check_value("rom_req", rom_req, 1'b0);
		check_value("z80_wait_n", z80_wait_n, 1'b1);
		check_value("z80_busreq_n", z80_busreq_n, 1'b1);
		check_value("z80_reset_n", z80_reset_n, 1'b0);

		count_enables();
		for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
			run_row(rows[row_idx]);
		finish_run();
	end

endmodule

`default_nettype wire

// File: hw/system_bus.sv
/*
 * Console bus fabric top level
 * Clock enables, decoder, main-bus arbiter, work RAM and sound bus
 */
`timescale 1ns/1ps
`default_nettype none

module system_bus #(
	parameter int ROM_BYTES = 'h400000
) (
	input  wire                             MCLK,
	input  wire                             reset,
	input  wire sysbus_pkg::m68k_req_t      m68k_req,
	output logic [15:0]                     m68k_rdata,
	output logic                            m68k_dtack_n,
	input  wire sysbus_pkg::z80_req_t       z80_req,
	output logic [7:0]                      z80_rdata,
	output logic                            z80_wait_n,
	output logic [sysbus_pkg::MBUS_AW-1:0]  rom_addr,
	output logic                            rom_req,
	input  wire                             rom_ack,
	input  wire [15:0]                      rom_data,
	output logic                            z80_reset_n,
	output logic                            z80_busreq_n,
	output logic                            m68k_ce_p,
	output logic                            m68k_ce_n,
	output logic                            z80_ce
);

	sysbus_pkg::mbus_cmd_t          mbus_cmd;
	sysbus_pkg::zbus_cmd_t          zbus_cmd;
	sysbus_pkg::target_t            target;
	logic [15:0]                    ram_rdata;
	logic                           ram_we_u;
	logic                           ram_we_l;
	logic [7:0]                     zbus_rdata;
	logic                           zbus_dtack_n;
	logic [7:0]                     z80_mbus_rdata;
	logic                           z80_mbus_dtack_n;
	logic [7:0]                     z80_zbus_rdata;
	logic                           z80_zbus_dtack_n;
	logic [sysbus_pkg::BAR_W-1:0]   bank_addr;

	assign rom_addr = mbus_cmd.addr;

	// Z80 waits until either side acknowledges
	assign z80_wait_n = !(sysbus_pkg::z80_active(z80_req) && z80_mbus_dtack_n &&
		z80_zbus_dtack_n);
	assign z80_rdata = !z80_zbus_dtack_n ? z80_zbus_rdata : z80_mbus_rdata;

	clock_enables u_clock_enables (
		.MCLK      (MCLK),
		.reset     (reset),
		.m68k_ce_p (m68k_ce_p),
		.m68k_ce_n (m68k_ce_n),
		.z80_ce    (z80_ce)
	);

	main_decode #(
		.ROM_BYTES (ROM_BYTES)
	) u_main_decode (
		.addr   (mbus_cmd.addr),
		.target (target)
	);

	main_bus u_main_bus (
		.MCLK             (MCLK),
		.reset            (reset),
		.m68k_ce_n        (m68k_ce_n),
		.m68k_req         (m68k_req),
		.z80_req          (z80_req),
		.bank_addr        (bank_addr),
		.target           (target),
		.ram_rdata        (ram_rdata),
		.rom_ack          (rom_ack),
		.rom_data         (rom_data),
		.zbus_rdata       (zbus_rdata),
		.zbus_dtack_n     (zbus_dtack_n),
		.mbus_cmd         (mbus_cmd),
		.ram_we_u         (ram_we_u),
		.ram_we_l         (ram_we_l),
		.rom_req          (rom_req),
		.zbus_cmd         (zbus_cmd),
		.m68k_rdata       (m68k_rdata),
		.m68k_dtack_n     (m68k_dtack_n),
		.z80_rdata        (z80_mbus_rdata),
		.z80_mbus_dtack_n (z80_mbus_dtack_n),
		.z80_busreq_n     (z80_busreq_n),
		.z80_reset_n      (z80_reset_n)
	);

	// 64 KB, mirrored over E00000-FFFFFF
	work_ram u_work_ram (
		.MCLK  (MCLK),
		.addr  (mbus_cmd.addr[14:0]),
		.wdata (mbus_cmd.data),
		.we_u  (ram_we_u),
		.we_l  (ram_we_l),
		.rdata (ram_rdata)
	);

	z80_bus u_z80_bus (
		.MCLK             (MCLK),
		.reset            (reset),
		.zbus_cmd         (zbus_cmd),
		.z80_req          (z80_req),
		.z80_busreq_n     (z80_busreq_n),
		.z80_reset_n      (z80_reset_n),
		.zbus_rdata       (zbus_rdata),
		.zbus_dtack_n     (zbus_dtack_n),
		.z80_zbus_rdata   (z80_zbus_rdata),
		.z80_zbus_dtack_n (z80_zbus_dtack_n),
		.bank_addr        (bank_addr)
	);

endmodule

`default_nettype wire

// File: hw/z80_bus.sv
/*
 * Sound-CPU bus arbiter
 * 8 KB Z80 RAM and the serially loaded bank register
 * Main bus has priority over the Z80
 */
`timescale 1ns/1ps
`default_nettype none

module z80_bus (
	input  wire                          MCLK,
	input  wire                          reset,
	input  wire sysbus_pkg::zbus_cmd_t   zbus_cmd,
	input  wire sysbus_pkg::z80_req_t    z80_req,
	input  wire                          z80_busreq_n,
	input  wire                          z80_reset_n,
	output logic [7:0]                   zbus_rdata,
	output logic                         zbus_dtack_n,
	output logic [7:0]                   z80_zbus_rdata,
	output logic                         z80_zbus_dtack_n,
	output logic [sysbus_pkg::BAR_W-1:0] bank_addr
);

	typedef enum logic [1:0] {
		Z_IDLE,
		Z_READ,
		Z_FINISH
	} zstate_t;

	zstate_t                      state;
	logic                         from_mbus;
	logic                         granted;
	logic                         z80_sel;
	logic [sysbus_pkg::ZBUS_AW-1:0] zaddr;
	logic [7:0]                   zwdata;
	logic                         zwe;
	logic                         ram_sel;
	logic                         bank_sel;
	logic [7:0]                   zram [8192];
	logic [7:0]                   zram_q;
	logic [7:0]                   bus_rdata;

	assign granted = !z80_busreq_n && z80_reset_n;
	// Z80 0000-7FFF
	assign z80_sel = sysbus_pkg::z80_active(z80_req) && !z80_req.addr[15];

	// RAM 0000-1FFF mirrored to 3FFF, bank register 6000-60FF
	assign ram_sel = !zaddr[14];
	assign bank_sel = zaddr[14:8] == 7'h60;
	assign bus_rdata = ram_sel ? zram_q : sysbus_pkg::OPEN_ZBUS;

	always_ff @(posedge MCLK) begin
		if (zwe && ram_sel)
			zram[zaddr[12:0]] <= zwdata;
		zram_q <= zram[zaddr[12:0]];
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= Z_IDLE;
			from_mbus <= 1'b0;
			zwe <= 1'b0;
			zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n <= 1'b1;
			bank_addr <= '0;
		end else begin
			zwe <= 1'b0;
			if (!zbus_cmd.sel)
				zbus_dtack_n <= 1'b1;
			if (!z80_sel)
				z80_zbus_dtack_n <= 1'b1;

			// Bit 0 shifts in at the top
			if (zwe && bank_sel)
				bank_addr <= {zwdata[0], bank_addr[sysbus_pkg::BAR_W-1:1]};

			case (state)
			Z_IDLE: begin
				if (zbus_cmd.sel && zbus_dtack_n) begin
					// Upper strobe selects the even byte
					zaddr <= {zbus_cmd.cmd.addr[sysbus_pkg::ZBUS_AW-2:0], zbus_cmd.cmd.uds_n};
					zwdata <= zbus_cmd.cmd.uds_n ? zbus_cmd.cmd.data[7:0] :
						zbus_cmd.cmd.data[15:8];
					zwe <= !zbus_cmd.cmd.rnw && granted;
					from_mbus <= 1'b1;
					state <= Z_READ;
				end else if (z80_sel && z80_zbus_dtack_n) begin
					zaddr <= z80_req.addr[sysbus_pkg::ZBUS_AW-1:0];
					zwdata <= z80_req.wdata;
					zwe <= !z80_req.wr_n;
					from_mbus <= 1'b0;
					state <= Z_READ;
				end
			end

			Z_READ: state <= Z_FINISH;

			Z_FINISH: begin
				if (from_mbus) begin
					zbus_rdata <= granted ? bus_rdata : 8'hFF;
					zbus_dtack_n <= 1'b0;
				end else begin
					z80_zbus_rdata <= bus_rdata;
					z80_zbus_dtack_n <= 1'b0;
				end
				state <= Z_IDLE;
			end

			default: state <= Z_IDLE;
			endcase
		end
	end

	// Main side writes RAM only while the bus is granted and the Z80 is out of reset
	assert property (@(posedge MCLK) disable iff (reset)
		(zwe && ram_sel && from_mbus) |-> (!z80_busreq_n && z80_reset_n));

endmodule

`default_nettype wire

// File: hw/work_ram.sv
/*
 * 68K work RAM, 32K x 16
 * Separate upper and lower byte-lane writes, registered read
 */
`timescale 1ns/1ps
`default_nettype none

module work_ram (
	input  wire         MCLK,
	input  wire  [14:0] addr,
	input  wire  [15:0] wdata,
	input  wire         we_u,
	input  wire         we_l,
	output logic [15:0] rdata
);

	// Lane 1 is the upper byte
	logic [1:0][7:0] mem [2**15];

	always_ff @(posedge MCLK) begin
		if (we_u)
			mem[addr][1] <= wdata[15:8];
		if (we_l)
			mem[addr][0] <= wdata[7:0];
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: hw/main_bus.sv
/*
 * Main-bus arbiter
 * Serves the 68K and the banked Z80 window, one transfer at a time
 * Holds the Z80 bus request and reset control register
 */
`timescale 1ns/1ps
`default_nettype none

module main_bus (
	input  wire                           MCLK,
	input  wire                           reset,
	input  wire                           m68k_ce_n,
	input  wire sysbus_pkg::m68k_req_t    m68k_req,
	input  wire sysbus_pkg::z80_req_t     z80_req,
	input  wire [sysbus_pkg::BAR_W-1:0]   bank_addr,
	input  wire sysbus_pkg::target_t      target,
	input  wire [15:0]                    ram_rdata,
	input  wire                           rom_ack,
	input  wire [15:0]                    rom_data,
	input  wire [7:0]                     zbus_rdata,
	input  wire                           zbus_dtack_n,
	output sysbus_pkg::mbus_cmd_t         mbus_cmd,
	output logic                          ram_we_u,
	output logic                          ram_we_l,
	output logic                          rom_req,
	output sysbus_pkg::zbus_cmd_t         zbus_cmd,
	output logic [15:0]                   m68k_rdata,
	output logic                          m68k_dtack_n,
	output logic [7:0]                    z80_rdata,
	output logic                          z80_mbus_dtack_n,
	output logic                          z80_busreq_n,
	output logic                          z80_reset_n
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SELECT,
		S_LOCAL,
		S_ROM,
		S_ZBUS,
		S_FINISH
	} state_t;

	state_t      state;
	logic        from_z80;
	logic        zsel;
	logic [15:0] rd_word;
	logic        ctrl_bit;
	logic        ctrl_wr;
	logic        take_68k;
	logic        take_z80;
	logic        strobe_moved;

	// 68K only on its falling phase, Z80 window only for 8000-FFFF
	assign take_68k = !m68k_req.as_n && m68k_dtack_n && m68k_ce_n;
	assign take_z80 = sysbus_pkg::z80_active(z80_req) && z80_req.addr[15] &&
		z80_mbus_dtack_n;
	assign strobe_moved = {m68k_req.uds_n, m68k_req.lds_n} != {mbus_cmd.uds_n, mbus_cmd.lds_n};

	assign zbus_cmd = '{sel: zsel, cmd: mbus_cmd};

	// Byte-lane writes in the single local-access cycle
	assign ram_we_u = state == S_LOCAL && target == sysbus_pkg::TGT_RAM &&
		!mbus_cmd.rnw && !mbus_cmd.uds_n;
	assign ram_we_l = state == S_LOCAL && target == sysbus_pkg::TGT_RAM &&
		!mbus_cmd.rnw && !mbus_cmd.lds_n;
	assign ctrl_wr = state == S_LOCAL && target == sysbus_pkg::TGT_CTRL &&
		!mbus_cmd.rnw && !mbus_cmd.uds_n;

	// Address bits 11..8 pick the register
	always_comb begin
		case (mbus_cmd.addr[10:7])
			4'd1: ctrl_bit = z80_busreq_n;
			4'd2: ctrl_bit = z80_reset_n;
			default: ctrl_bit = 1'b0;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= S_IDLE;
			from_z80 <= 1'b0;
			zsel <= 1'b0;
			rom_req <= 1'b0;
			m68k_dtack_n <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else begin
			// Acknowledges release once the master ends its cycle
			if (m68k_req.as_n)
				m68k_dtack_n <= 1'b1;
			if (!sysbus_pkg::z80_active(z80_req))
				z80_mbus_dtack_n <= 1'b1;

			case (state)
			S_IDLE: begin
				if (take_68k) begin
					from_z80 <= 1'b0;
					mbus_cmd <= '{
						addr:  m68k_req.addr,
						data:  m68k_req.wdata,
						rnw:   m68k_req.rnw,
						uds_n: m68k_req.uds_n,
						lds_n: m68k_req.lds_n
					};
					state <= S_SELECT;
				end else if (take_z80) begin
					from_z80 <= 1'b1;
					mbus_cmd <= '{
						addr:  {bank_addr, z80_req.addr[14:1]},
						data:  {z80_req.wdata, z80_req.wdata},
						rnw:   z80_req.wr_n,
						uds_n: z80_req.addr[0],
						lds_n: ~z80_req.addr[0]
					};
					state <= S_SELECT;
				end
			end

			S_SELECT: begin
				case (target)
					sysbus_pkg::TGT_ROM: begin
						rom_req <= ~rom_ack;
						state <= S_ROM;
					end
					sysbus_pkg::TGT_ZBUS: begin
						zsel <= 1'b1;
						state <= S_ZBUS;
					end
					default: state <= S_LOCAL;
				endcase
			end

			// RAM, control register and unmapped space
			S_LOCAL: begin
				case (target)
					sysbus_pkg::TGT_RAM: rd_word <= ram_rdata;
					sysbus_pkg::TGT_CTRL: rd_word <= {7'd0, ctrl_bit, 8'd0};
					default: rd_word <= 16'h0000;
				endcase
				if (ctrl_wr && mbus_cmd.addr[10:7] == 4'd1)
					z80_busreq_n <= ~mbus_cmd.data[8];
				if (ctrl_wr && mbus_cmd.addr[10:7] == 4'd2)
					z80_reset_n <= mbus_cmd.data[8];
				state <= S_FINISH;
			end

			S_ROM: begin
				if (rom_req == rom_ack) begin
					rd_word <= rom_data;
					state <= S_FINISH;
				end
			end

			S_ZBUS: begin
				if (!zbus_dtack_n) begin
					zsel <= 1'b0;
					rd_word <= {zbus_rdata, zbus_rdata};
					state <= S_FINISH;
				end
			end

			S_FINISH: begin
				if (from_z80) begin
					// Odd Z80 address reads the low byte
					z80_rdata <= mbus_cmd.uds_n ? rd_word[7:0] : rd_word[15:8];
					z80_mbus_dtack_n <= 1'b0;
					state <= S_IDLE;
				end else begin
					m68k_rdata <= rd_word;
					m68k_dtack_n <= 1'b0;
					// Hold here while the 68K keeps the same cycle
					if (m68k_req.as_n || strobe_moved)
						state <= S_IDLE;
				end
			end

			default: state <= S_IDLE;
			endcase
		end
	end

	// A new ROM request only follows a ROM decode in SELECT
	assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> $past(state == S_SELECT && target == sysbus_pkg::TGT_ROM));

endmodule

`default_nettype wire

// File: hw/main_decode.sv
/*
 * Main-bus address decoder
 * Maps a word address to ROM, work RAM, sound bus, control register or nothing
 */
`timescale 1ns/1ps
`default_nettype none

module main_decode #(
	parameter int ROM_BYTES = 'h400000
) (
	input  wire [sysbus_pkg::MBUS_AW-1:0] addr,
	output sysbus_pkg::target_t           target
);

	logic [sysbus_pkg::MBUS_AW:0] byte_addr;

	assign byte_addr = {addr, 1'b0};

	always_comb begin
		if (byte_addr < ROM_BYTES)
			target = sysbus_pkg::TGT_ROM;
		// E00000-FFFFFF
		else if (byte_addr[23:21] == 3'b111)
			target = sysbus_pkg::TGT_RAM;
		// A00000-A0FFFF
		else if (byte_addr[23:16] == 8'hA0)
			target = sysbus_pkg::TGT_ZBUS;
		// A11100 and A11200, low byte zero
		else if (byte_addr[23:12] == 12'hA11 && byte_addr[7:0] == 8'h00)
			target = sysbus_pkg::TGT_CTRL;
		else
			target = sysbus_pkg::TGT_NONE;
	end

endmodule

`default_nettype wire

// File: hw/clock_enables.sv
/*
 * Clock enable generator
 * Two 68K phase strobes and the Z80 enable, divided down from MCLK
 */
`timescale 1ns/1ps
`default_nettype none

module clock_enables (
	input  wire  MCLK,
	input  wire  reset,
	output logic m68k_ce_p,
	output logic m68k_ce_n,
	output logic z80_ce
);

	localparam int M68K_CW = $clog2(sysbus_pkg::M68K_DIV);
	localparam int Z80_CW = $clog2(sysbus_pkg::Z80_DIV);
	// Falling phase halfway through the 68K period
	localparam int M68K_MID = sysbus_pkg::M68K_DIV / 2;

	logic [M68K_CW-1:0] m68k_cnt;
	logic [Z80_CW-1:0]  z80_cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			m68k_cnt <= '0;
			z80_cnt <= '0;
			m68k_ce_p <= 1'b0;
			m68k_ce_n <= 1'b0;
			z80_ce <= 1'b0;
		end else begin
			m68k_ce_n <= m68k_cnt == M68K_CW'(M68K_MID);
			m68k_ce_p <= m68k_cnt == M68K_CW'(sysbus_pkg::M68K_DIV - 1);
			if (m68k_cnt == M68K_CW'(sysbus_pkg::M68K_DIV - 1))
				m68k_cnt <= '0;
			else
				m68k_cnt <= m68k_cnt + 1'b1;

			z80_ce <= z80_cnt == Z80_CW'(sysbus_pkg::Z80_DIV - 1);
			if (z80_cnt == Z80_CW'(sysbus_pkg::Z80_DIV - 1))
				z80_cnt <= '0;
			else
				z80_cnt <= z80_cnt + 1'b1;
		end
	end

	// The two 68K phases never coincide
	assert property (@(posedge MCLK) disable iff (reset) !(m68k_ce_p && m68k_ce_n));

endmodule

`default_nettype wire

// File: hw/sysbus_pkg.sv
/*
 * Shared definitions of the console bus fabric
 * Request structs of the 68K and Z80 master ports
 * Main-bus command and sound-bus request structs
 * Address decoder targets, bus widths and divider periods
 */
`default_nettype none

package sysbus_pkg;

	// Widths
	localparam int MBUS_AW = 23;
	localparam int ZBUS_AW = 15;
	localparam int BAR_W = 9;

	// Clock enable periods in MCLK cycles
	localparam int M68K_DIV = 7;
	localparam int Z80_DIV = 15;

	// Unmapped sound-bus read
	localparam logic [7:0] OPEN_ZBUS = 8'hFF;

	// 68K master request, word addressed
	typedef struct packed {
		logic [MBUS_AW-1:0] addr;
		logic [15:0]        wdata;
		logic               rnw;
		logic               as_n;
		logic               uds_n;
		logic               lds_n;
	} m68k_req_t;

	// Z80 master request, byte addressed
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        mreq_n;
		logic        rd_n;
		logic        wr_n;
	} z80_req_t;

	// Transfer latched by the main-bus arbiter
	typedef struct packed {
		logic [MBUS_AW-1:0] addr;
		logic [15:0]        data;
		logic               rnw;
		logic               uds_n;
		logic               lds_n;
	} mbus_cmd_t;

	// Main bus into the sound-CPU bus
	typedef struct packed {
		logic      sel;
		mbus_cmd_t cmd;
	} zbus_cmd_t;

	typedef enum logic [2:0] {
		TGT_NONE,
		TGT_ROM,
		TGT_RAM,
		TGT_ZBUS,
		TGT_CTRL
	} target_t;

	// Z80 memory cycle in progress
	function automatic logic z80_active(z80_req_t req);
		return !req.mreq_n && (!req.rd_n || !req.wr_n);
	endfunction

endpackage

`default_nettype wire
